/* verilog/spec_pkg.sv */
`default_nettype none

package spec_pkg;

    // stream geometry
    localparam int din_width    = 12;
    localparam int vector_len   = 16;
    localparam int chan_width   = 4;
    localparam int power_width  = 2 * din_width;
    localparam int power_shift  = 4;
    localparam int acc_in_width = 16;
    localparam int acc_width    = 32;
    localparam int frames_width = 16;

    // bus geometry
    localparam int wb_adr_width  = 5;
    localparam int wb_data_width = 32;

    typedef logic signed [din_width-1:0] sample_t;
    typedef logic [power_width-1:0]      power_t;
    typedef logic [acc_in_width-1:0]     acc_in_t;
    typedef logic [acc_width-1:0]        acc_t;
    typedef logic [chan_width-1:0]       chan_t;
    typedef logic [wb_adr_width-1:0]     wb_adr_t;
    typedef logic [wb_data_width-1:0]    wb_data_t;
    typedef logic [frames_width-1:0]     frames_t;

    // register window sits right above the spectrum words
    localparam wb_adr_t adr_acc_len = wb_adr_t'(16);
    localparam wb_adr_t adr_status  = wb_adr_t'(17);

    localparam frames_t acc_len_reset = frames_t'(4);

    typedef enum logic [1:0] {
        idle,
        prime,
        run
    } ctl_state_t;

endpackage

`default_nettype wire

/* verilog/complex_power.sv */
`timescale 1ns/100ps
`default_nettype none

module complex_power (
    input  wire                   clk,
    input  wire                   cnt_rst,
    input  wire spec_pkg::sample_t din_re,
    input  wire spec_pkg::sample_t din_im,
    input  wire                   din_valid,
    input  wire                   sync_in,
    output spec_pkg::power_t      power,
    output logic                  power_valid,
    output logic                  power_sync
);

    // full precision squares, always non-negative
    logic signed [spec_pkg::power_width-1:0] sq_re;
    logic signed [spec_pkg::power_width-1:0] sq_im;
    logic                                    sq_valid;
    logic                                    sq_sync;

    always_ff @(posedge clk) begin
        sq_re <= din_re * din_re;
        sq_im <= din_im * din_im;
        // sum of two squares can reach 2^23, still fits unsigned
        power <= spec_pkg::power_t'(sq_re + sq_im);
    end

    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            sq_valid    <= 1'b0;
            sq_sync     <= 1'b0;
            power_valid <= 1'b0;
            power_sync  <= 1'b0;
        end else begin
            sq_valid    <= din_valid;
            sq_sync     <= din_valid && sync_in;
            power_valid <= sq_valid;
            power_sync  <= sq_sync;
        end
    end

    // sync must stay tied to a real sample through both stages
    a_sync_has_valid: assert property (
        @(posedge clk) disable iff (cnt_rst)
        power_sync |-> power_valid
    );

endmodule

`default_nettype wire

/* verilog/power_cast.sv */
`timescale 1ns/100ps
`default_nettype none

module power_cast (
    input  wire                  clk,
    input  wire                  cnt_rst,
    input  wire spec_pkg::power_t power,
    input  wire                  power_valid,
    input  wire                  power_sync,
    output spec_pkg::acc_in_t    cast_data,
    output logic                 cast_valid,
    output logic                 cast_sync,
    output logic                 warning
);

    localparam int shifted_width = spec_pkg::power_width - spec_pkg::power_shift;

    logic [shifted_width-1:0] shifted;
    logic                     overflow;

    assign shifted = shifted_width'(power >> spec_pkg::power_shift);
    // anything above the accumulator input range
    assign overflow = |shifted[shifted_width-1:spec_pkg::acc_in_width];

    always_ff @(posedge clk) begin
        if (overflow) begin
            cast_data <= '1;
        end else begin
            cast_data <= shifted[spec_pkg::acc_in_width-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            cast_valid <= 1'b0;
            cast_sync  <= 1'b0;
            warning    <= 1'b0;
        end else begin
            cast_valid <= power_valid;
            cast_sync  <= power_sync;
            warning    <= power_valid && overflow;
        end
    end

endmodule

`default_nettype wire

/* verilog/acc_control.sv */
`timescale 1ns/100ps
`default_nettype none

module acc_control (
    input  wire                   clk,
    input  wire                   cnt_rst,
    input  wire                   cast_valid,
    input  wire                   cast_sync,
    input  wire spec_pkg::frames_t acc_len,
    output spec_pkg::chan_t       chan,
    output logic                  first_frame,
    output logic                  dump_en,
    output logic                  dump_done
);

    spec_pkg::ctl_state_t state;
    spec_pkg::chan_t      chan_cnt;
    spec_pkg::frames_t    frame_cnt;
    spec_pkg::frames_t    len_cur;
    spec_pkg::frames_t    len_eff;
    logic                 take;
    logic                 last_chan;
    logic                 last_frame;

    // zero frames makes no sense, run as one
    assign len_eff = (acc_len == '0) ? spec_pkg::frames_t'(1) : acc_len;

    // a sync always realigns to channel 0
    assign chan        = (cast_valid && cast_sync) ? '0 : chan_cnt;
    assign first_frame = (frame_cnt == '0);
    assign dump_en     = (state == spec_pkg::run);

    assign take       = cast_valid && (state != spec_pkg::idle || cast_sync);
    assign last_chan  = (chan == spec_pkg::chan_t'(spec_pkg::vector_len - 1));
    assign last_frame = (frame_cnt == len_cur - 1'b1);

    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            state     <= spec_pkg::idle;
            chan_cnt  <= '0;
            frame_cnt <= '0;
            len_cur   <= spec_pkg::acc_len_reset;
            dump_done <= 1'b0;
        end else begin
            // lines up with sum_valid of the last channel
            dump_done <= take && last_chan && first_frame && dump_en;
            if (take) begin
                chan_cnt <= last_chan ? '0 : chan + 1'b1;
                case (state)
                    spec_pkg::idle: begin
                        state   <= spec_pkg::prime;
                        len_cur <= len_eff;
                    end
                    default: begin
                        if (last_chan && last_frame) begin
                            // integration boundary, pick up a new acc_len here
                            frame_cnt <= '0;
                            len_cur   <= len_eff;
                            state     <= spec_pkg::run;
                        end else if (last_chan) begin
                            frame_cnt <= frame_cnt + 1'b1;
                        end
                    end
                endcase
            end
        end
    end

    a_sync_aligned: assert property (
        @(posedge clk) disable iff (cnt_rst)
        (cast_valid && cast_sync) |-> (state == spec_pkg::idle || chan_cnt == '0)
    );

endmodule

`default_nettype wire

/* verilog/vector_accumulator.sv */
`timescale 1ns/100ps
`default_nettype none

module vector_accumulator (
    input  wire                   clk,
    input  wire                   cnt_rst,
    input  wire spec_pkg::acc_in_t cast_data,
    input  wire                   cast_valid,
    input  wire spec_pkg::chan_t   chan,
    input  wire                   first_frame,
    input  wire                   dump_en,
    output spec_pkg::acc_t        sum_out,
    output spec_pkg::chan_t       sum_chan,
    output logic                  sum_valid
);

    // one running sum per channel
    spec_pkg::acc_t sums [spec_pkg::vector_len];

    always_ff @(posedge clk) begin
        if (cast_valid) begin
            if (first_frame) begin
                // hand out the finished sum, restart with this sample
                sum_out    <= sums[chan];
                sums[chan] <= spec_pkg::acc_t'(cast_data);
            end else begin
                sums[chan] <= sums[chan] + spec_pkg::acc_t'(cast_data);
            end
            sum_chan <= chan;
        end
    end

    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= cast_valid && first_frame && dump_en;
        end
    end

endmodule

`default_nettype wire

/* verilog/spectrum_ram_wb.sv */
`timescale 1ns/100ps
`default_nettype none

module spectrum_ram_wb (
    input  wire                    clk,
    input  wire                    cnt_rst,
    input  wire spec_pkg::acc_t     sum_out,
    input  wire spec_pkg::chan_t    sum_chan,
    input  wire                    sum_valid,
    input  wire                    dump_done,
    input  wire                    warning,
    output spec_pkg::frames_t      acc_len,
    input  wire                    wb_cyc,
    input  wire                    wb_stb,
    input  wire                    wb_we,
    input  wire spec_pkg::wb_adr_t  wb_adr,
    input  wire spec_pkg::wb_data_t wb_dat_w,
    output spec_pkg::wb_data_t     wb_dat_r,
    output logic                   wb_ack
);

    spec_pkg::acc_t ram [spec_pkg::vector_len];

    logic [15:0] int_count;
    logic        warn_sticky;
    logic        have_data;
    logic        req;
    logic        rd_status;
    logic        in_ram;

    // ack drops for a cycle after every transfer
    assign req       = wb_cyc && wb_stb && !wb_ack;
    assign rd_status = req && !wb_we && (wb_adr == spec_pkg::adr_status);
    assign in_ram    = (wb_adr < spec_pkg::wb_adr_t'(spec_pkg::vector_len));

    always_ff @(posedge clk) begin
        if (sum_valid) begin
            ram[sum_chan] <= sum_out;
        end
    end

    always_ff @(posedge clk) begin
        if (cnt_rst) begin
            wb_ack      <= 1'b0;
            acc_len     <= spec_pkg::acc_len_reset;
            int_count   <= '0;
            warn_sticky <= 1'b0;
            have_data   <= 1'b0;
        end else begin
            wb_ack <= req;
            // RAM words are read only, a write there is just acked
            if (req && wb_we && wb_adr == spec_pkg::adr_acc_len) begin
                acc_len <= wb_dat_w[spec_pkg::frames_width-1:0];
            end
            if (dump_done) begin
                int_count <= int_count + 1'b1;
                have_data <= 1'b1;
            end
            // a new warning wins over the clear on read
            if (warning) begin
                warn_sticky <= 1'b1;
            end else if (rd_status) begin
                warn_sticky <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && !wb_we) begin
            if (in_ram) begin
                wb_dat_r <= ram[wb_adr[spec_pkg::chan_width-1:0]];
            end else if (wb_adr == spec_pkg::adr_acc_len) begin
                wb_dat_r <= spec_pkg::wb_data_t'(acc_len);
            end else if (wb_adr == spec_pkg::adr_status) begin
                wb_dat_r <= spec_pkg::wb_data_t'({have_data, warn_sticky, int_count});
            end else begin
                wb_dat_r <= '0;
            end
        end
    end

    a_ack_single: assert property (
        @(posedge clk) disable iff (cnt_rst)
        wb_ack |=> !wb_ack
    );

endmodule

`default_nettype wire

/* verilog/spectrometer_lane.sv */
`timescale 1ns/100ps
`default_nettype none

module spectrometer_lane (
    input  wire                    clk,
    input  wire                    cnt_rst,
    input  wire spec_pkg::sample_t  din_re,
    input  wire spec_pkg::sample_t  din_im,
    input  wire                    din_valid,
    input  wire                    sync_in,
    input  wire                    wb_cyc,
    input  wire                    wb_stb,
    input  wire                    wb_we,
    input  wire spec_pkg::wb_adr_t  wb_adr,
    input  wire spec_pkg::wb_data_t wb_dat_w,
    output spec_pkg::wb_data_t     wb_dat_r,
    output logic                   wb_ack
);

    spec_pkg::power_t  power;
    logic              power_valid;
    logic              power_sync;
    spec_pkg::acc_in_t cast_data;
    logic              cast_valid;
    logic              cast_sync;
    logic              warning;
    spec_pkg::chan_t   chan;
    logic              first_frame;
    logic              dump_en;
    logic              dump_done;
    spec_pkg::frames_t acc_len;
    spec_pkg::acc_t    sum_out;
    spec_pkg::chan_t   sum_chan;
    logic              sum_valid;

    complex_power u_power (
        .clk         (clk),
        .cnt_rst     (cnt_rst),
        .din_re      (din_re),
        .din_im      (din_im),
        .din_valid   (din_valid),
        .sync_in     (sync_in),
        .power       (power),
        .power_valid (power_valid),
        .power_sync  (power_sync)
    );

    power_cast u_cast (
        .clk         (clk),
        .cnt_rst     (cnt_rst),
        .power       (power),
        .power_valid (power_valid),
        .power_sync  (power_sync),
        .cast_data   (cast_data),
        .cast_valid  (cast_valid),
        .cast_sync   (cast_sync),
        .warning     (warning)
    );

    acc_control u_ctl (
        .clk         (clk),
        .cnt_rst     (cnt_rst),
        .cast_valid  (cast_valid),
        .cast_sync   (cast_sync),
        .acc_len     (acc_len),
        .chan        (chan),
        .first_frame (first_frame),
        .dump_en     (dump_en),
        .dump_done   (dump_done)
    );

    vector_accumulator u_acc (
        .clk         (clk),
        .cnt_rst     (cnt_rst),
        .cast_data   (cast_data),
        .cast_valid  (cast_valid),
        .chan        (chan),
        .first_frame (first_frame),
        .dump_en     (dump_en),
        .sum_out     (sum_out),
        .sum_chan    (sum_chan),
        .sum_valid   (sum_valid)
    );

    spectrum_ram_wb u_ram (
        .clk         (clk),
        .cnt_rst     (cnt_rst),
        .sum_out     (sum_out),
        .sum_chan    (sum_chan),
        .sum_valid   (sum_valid),
        .dump_done   (dump_done),
        .warning     (warning),
        .acc_len     (acc_len),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack)
    );

endmodule

`default_nettype wire

/* bench/tb_spectrometer_lane.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_spectrometer_lane;

    logic                 clk;
    logic                 cnt_rst;
    spec_pkg::sample_t    din_re;
    spec_pkg::sample_t    din_im;
    logic                 din_valid;
    logic                 sync_in;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    spec_pkg::wb_adr_t    wb_adr;
    spec_pkg::wb_data_t   wb_dat_w;
    spec_pkg::wb_data_t   wb_dat_r;
    logic                 wb_ack;

    // re base, im base, channel step, gap flag
    // bin ch carries re = re base + ch*step, im = im base - ch*step
    int tbl [16][4] = '{
        '{100, -50, 10, 0},
        '{-200, 30, 15, 0},
        '{300, 120, -12, 0},
        '{-40, -400, 20, 0},
        '{500, 250, -20, 0},
        '{-600, 10, 25, 0},
        '{300, 120, -12, 1},
        '{-40, -400, 20, 1},
        '{-2048, -2048, 0, 1},
        '{250, -250, 8, 0},
        '{-123, 321, 5, 1},
        '{77, -100, 30, 0},
        '{-500, 400, 10, 1},
        '{640, -640, -1, 0},
        '{1, 2, 3, 1},
        '{-7, 600, -9, 0}
    };

    // reference model state
    logic [31:0] m_sum [16];
    logic [31:0] m_ram [16];
    logic [31:0] ram_rd [16];
    logic [31:0] snap [16];
    logic        m_started;
    logic        m_run;
    int          m_frame;
    int          m_len;
    int          m_acc_len;
    int          m_count;
    logic [7:0]  lfsr;

    spectrometer_lane dut0 (
        .clk       (clk),
        .cnt_rst   (cnt_rst),
        .din_re    (din_re),
        .din_im    (din_im),
        .din_valid (din_valid),
        .sync_in   (sync_in),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // inputs change and outputs are sampled 10 ns after the edge
    task automatic tick();
        @(posedge clk);
        #10;
    endtask

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Mismatch at time %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Something failed");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic report_timeout(input string why);
        $display("Timeout at time %0t: %s", $time, why);
        $display("Something failed");
        $fatal(1, "timeout");
    endtask

    // galois lfsr, x^8 + x^6 + x^5 + x^4 + 1
    function automatic int lfsr_bit();
        int b;
        b = int'(lfsr[0]);
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 8'hb8) : (lfsr >> 1);
        return b;
    endfunction

    function automatic logic [15:0] cast_power(input int re, input int im);
        int p;
        p = (re * re + im * im) >> 4;
        if (p > 65535) begin
            return 16'hffff;
        end
        return p[15:0];
    endfunction

    function automatic logic [31:0] status_exp(input logic warn);
        return {14'b0, 1'b1, warn, m_count[15:0]};
    endfunction

    task automatic wb_write(input spec_pkg::wb_adr_t adr, input spec_pkg::wb_data_t data);
        int n;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        n = 0;
        tick();
        while (!wb_ack && n < 16) begin
            tick();
            n++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!wb_ack) report_timeout("no ack on bus write");
    endtask

    task automatic wb_read(input spec_pkg::wb_adr_t adr, output spec_pkg::wb_data_t data);
        int n;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        n = 0;
        tick();
        while (!wb_ack && n < 16) begin
            tick();
            n++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        if (!wb_ack) report_timeout("no ack on bus read");
        else data = wb_dat_r;
    endtask

    // stb held high, expect an ack one cycle after the request and every second cycle
    task automatic back_to_back_reads(input logic [31:0] exp);
        int acks;
        int n;
        int last;
        // one idle cycle so the previous ack has dropped
        tick();
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = spec_pkg::adr_acc_len;
        acks = 0;
        n = 0;
        last = 0;
        while (acks < 2 && n < 16) begin
            tick();
            n++;
            if (wb_ack) begin
                if (acks == 0) check_eq("first ack latency", n, 1);
                else check_eq("cycles between acks", n - last, 2);
                check_eq("back-to-back read data", wb_dat_r, exp);
                acks++;
                last = n;
            end
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        if (acks < 2) report_timeout("held request did not get two acks");
    endtask

    task automatic set_acc_len(input int v);
        wb_write(spec_pkg::adr_acc_len, spec_pkg::wb_data_t'(v));
        m_acc_len = v;
    endtask

    // frame level model: load on a first frame, dump the old sum once running
    task automatic model_frame(input int r);
        int ch;
        logic [15:0] p;
        if (!m_started) begin
            m_started = 1'b1;
            m_len = (m_acc_len == 0) ? 1 : m_acc_len;
        end
        for (ch = 0; ch < spec_pkg::vector_len; ch++) begin
            p = cast_power(tbl[r][0] + ch * tbl[r][2], tbl[r][1] - ch * tbl[r][2]);
            if (m_frame == 0) begin
                if (m_run) m_ram[ch] = m_sum[ch];
                m_sum[ch] = 32'(p);
            end else begin
                m_sum[ch] = m_sum[ch] + 32'(p);
            end
        end
        if (m_frame == 0 && m_run) m_count++;
        m_frame++;
        if (m_frame == m_len) begin
            m_frame = 0;
            m_len = (m_acc_len == 0) ? 1 : m_acc_len;
            m_run = 1'b1;
        end
    endtask

    task automatic send_frame(input int r);
        int ch;
        int idle;
        for (ch = 0; ch < spec_pkg::vector_len; ch++) begin
            if (tbl[r][3] != 0) begin
                idle = lfsr_bit();
                idle = idle * 2 + lfsr_bit();
                repeat (idle) tick();
            end
            din_re    = spec_pkg::sample_t'(tbl[r][0] + ch * tbl[r][2]);
            din_im    = spec_pkg::sample_t'(tbl[r][1] - ch * tbl[r][2]);
            din_valid = 1'b1;
            sync_in   = (ch == 0);
            tick();
            din_valid = 1'b0;
            sync_in   = 1'b0;
        end
        model_frame(r);
    endtask

    task automatic wait_for_count(output logic [31:0] st);
        int polls;
        polls = 0;
        wb_read(spec_pkg::adr_status, st);
        while (st[15:0] != m_count[15:0] && polls < 50) begin
            wb_read(spec_pkg::adr_status, st);
            polls++;
        end
        if (st[15:0] != m_count[15:0]) report_timeout("integration count never reached");
    endtask

    task automatic check_ram();
        int ch;
        for (ch = 0; ch < spec_pkg::vector_len; ch++) begin
            wb_read(spec_pkg::wb_adr_t'(ch), ram_rd[ch]);
            check_eq($sformatf("spectrum word %0d", ch), ram_rd[ch], m_ram[ch]);
        end
    endtask

    initial begin
        logic [31:0] rd;
        int r;
        int ch;
        din_re    = '0;
        din_im    = '0;
        din_valid = 1'b0;
        sync_in   = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        cnt_rst   = 1'b1;
        m_started = 1'b0;
        m_run     = 1'b0;
        m_frame   = 0;
        m_len     = 4;
        m_acc_len = 4;
        m_count   = 0;
        lfsr      = 8'd38;
        repeat (5) tick();
        cnt_rst = 1'b0;

        // register window after reset
        wb_read(spec_pkg::adr_acc_len, rd);
        check_eq("acc_len after reset", rd, 4);
        wb_read(spec_pkg::adr_status, rd);
        check_eq("status after reset", rd, 0);
        set_acc_len(2);
        wb_read(spec_pkg::adr_acc_len, rd);
        check_eq("acc_len readback", rd, 2);
        back_to_back_reads(2);

        // first integration only primes
        for (r = 0; r < 6; r++) send_frame(r);
        wait_for_count(rd);
        check_eq("status after six frames", rd, status_exp(1'b0));
        check_ram();
        snap = ram_rd;

        // rows 2 and 3 again with idle gaps, then a saturating frame
        for (r = 6; r < 10; r++) send_frame(r);
        wait_for_count(rd);
        check_eq("status after saturation", rd, status_exp(1'b1));
        check_ram();
        for (ch = 0; ch < spec_pkg::vector_len; ch++) begin
            check_eq($sformatf("gapped sum %0d", ch), ram_rd[ch], snap[ch]);
        end
        wb_read(spec_pkg::adr_status, rd);
        check_eq("status after clear on read", rd, status_exp(1'b0));

        // new length applies after the current integration
        set_acc_len(3);
        send_frame(10);
        wait_for_count(rd);
        check_ram();
        for (r = 11; r < 16; r++) send_frame(r);
        wait_for_count(rd);
        check_eq("status after length change", rd, status_exp(1'b0));
        check_ram();
        wb_write(spec_pkg::wb_adr_t'(5), 32'hdeadbeef);
        check_ram();

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
verilog/spec_pkg.sv
verilog/complex_power.sv
verilog/power_cast.sv
verilog/acc_control.sv
verilog/vector_accumulator.sv
verilog/spectrum_ram_wb.sv
verilog/spectrometer_lane.sv
bench/tb_spectrometer_lane.sv

/* Makefile */
TOP = tb_spectrometer_lane

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP) -o sim
	./obj_dir/sim

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir
